/* mips_pkg.sv */
package mips_pkg;

    // primary opcodes.
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_SLTIU = 6'h0b;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_XORI  = 6'h0e;
    localparam logic [5:0] OP_LUI   = 6'h0f;

    // funct codes under OP_RTYPE.
    localparam logic [5:0] FN_SLL     = 6'h00;
    localparam logic [5:0] FN_SRL     = 6'h02;
    localparam logic [5:0] FN_SRA     = 6'h03;
    localparam logic [5:0] FN_SLLV    = 6'h04;
    localparam logic [5:0] FN_SRLV    = 6'h06;
    localparam logic [5:0] FN_SRAV    = 6'h07;
    localparam logic [5:0] FN_SYSCALL = 6'h0c;
    localparam logic [5:0] FN_BREAK   = 6'h0d;
    localparam logic [5:0] FN_MFHI    = 6'h10;
    localparam logic [5:0] FN_MTHI    = 6'h11;
    localparam logic [5:0] FN_MFLO    = 6'h12;
    localparam logic [5:0] FN_MTLO    = 6'h13;
    localparam logic [5:0] FN_MULT    = 6'h18;
    localparam logic [5:0] FN_MULTU   = 6'h19;
    localparam logic [5:0] FN_ADD     = 6'h20;
    localparam logic [5:0] FN_ADDU    = 6'h21;
    localparam logic [5:0] FN_SUB     = 6'h22;
    localparam logic [5:0] FN_SUBU    = 6'h23;
    localparam logic [5:0] FN_AND     = 6'h24;
    localparam logic [5:0] FN_OR      = 6'h25;
    localparam logic [5:0] FN_XOR     = 6'h26;
    localparam logic [5:0] FN_NOR     = 6'h27;
    localparam logic [5:0] FN_SLT     = 6'h2a;
    localparam logic [5:0] FN_SLTU    = 6'h2b;

    localparam logic [2:0] EXC_NONE     = 3'd0;
    localparam logic [2:0] EXC_OVERFLOW = 3'd1;
    localparam logic [2:0] EXC_RESERVED = 3'd2;
    localparam logic [2:0] EXC_SYSCALL  = 3'd3;
    localparam logic [2:0] EXC_BREAK    = 3'd4;

    // immediate forms carried in ctrl_t.imm_sel.
    localparam logic [1:0] IMM_NONE  = 2'd0;
    localparam logic [1:0] IMM_EXT   = 2'd1;
    localparam logic [1:0] IMM_UPPER = 2'd2;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,  ALU_SUB   = 4'd1,  ALU_AND  = 4'd2,  ALU_OR   = 4'd3,
        ALU_NOR  = 4'd4,  ALU_XOR   = 4'd5,  ALU_SLL  = 4'd6,  ALU_SRL  = 4'd7,
        ALU_SRA  = 4'd8,  ALU_SLT   = 4'd9,  ALU_SLTU = 4'd10, ALU_LUI  = 4'd11,
        ALU_MULT = 4'd12, ALU_MULTU = 4'd13, ALU_PASS = 4'd14
    } alu_op_e;

    typedef enum logic [1:0] {
        DEST_NONE = 2'd0,
        DEST_RD   = 2'd1,
        DEST_RT   = 2'd2
    } dest_sel_e;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_fields_t;

    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
    } instr_u;

    typedef struct packed {
        logic      sign_ext;
        logic [1:0] imm_sel;
        dest_sel_e dest_sel;
        logic      reg_write;
        logic      hi_read;
        logic      lo_read;
        logic      hi_write;
        logic      lo_write;
        logic      shift_var;
        logic      use_imm;
        alu_op_e   alu_op;
        logic      ovf_check;
    } ctrl_t;

    typedef struct packed {
        logic [31:0] pc;
        ctrl_t       ctrl;
        logic [4:0]  dest;
        logic [31:0] opa;
        logic [31:0] opb;
        logic [4:0]  shamt;
        logic        taken;
        logic [2:0]  exc;
    } dx_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  dest;
        logic        we;
        logic        hi_we;
        logic        lo_we;
        logic [31:0] value;
        logic [31:0] hi_val;
        logic [31:0] lo_val;
        logic        hi_rd;
        logic        lo_rd;
        logic        taken;
        logic [2:0]  exc;
    } xr_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  dest;
        logic        we;
        logic [31:0] wdata;
        logic        taken;
        logic [2:0]  exc;
    } retire_t;

    // writes still in flight in a later stage.
    typedef struct packed {
        logic [4:0] dest;
        logic       we;
        logic       hi_we;
        logic       lo_we;
        logic       valid;
    } pending_t;

endpackage

/* regfile.sv */
`timescale 1ns/100ps

module regfile (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    input  logic        wr_en,
    input  logic [4:0]  wr_addr,
    input  logic [31:0] wr_data,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data
);
    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != 5'd0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // no write bypass; decode interlocks instead.
    assign rs_data = (rs_addr == 5'd0) ? 32'b0 : regs[rs_addr];
    assign rt_data = (rt_addr == 5'd0) ? 32'b0 : regs[rt_addr];

endmodule

/* decode.sv */
`timescale 1ns/100ps

module decode (
    input  mips_pkg::instr_u   instr,
    input  logic [31:0]        pc,
    input  logic [31:0]        rs_data,
    input  logic [31:0]        rt_data,
    input  mips_pkg::pending_t pend_x,
    input  mips_pkg::pending_t pend_r,
    input  logic               dx_ready,
    output logic [4:0]         rs_addr,
    output logic [4:0]         rt_addr,
    output mips_pkg::dx_t      dx,
    output logic               stall
);
    logic [5:0]      op;
    logic [5:0]      funct;
    logic [15:0]     imm16;
    mips_pkg::ctrl_t ctrl;
    logic [2:0]      exc;
    logic [31:0]     ext_imm;
    logic [31:0]     imm;
    logic [4:0]      dest;
    logic            rs_used;
    logic            rt_used;
    logic            hazard;

    function automatic logic pending_hit(mips_pkg::pending_t p, logic [4:0] rs, logic [4:0] rt,
                                         logic use_rs, logic use_rt, logic hi_rd, logic lo_rd);
        logic reg_hit;
        logic hilo_hit;
        reg_hit = p.we && (p.dest != 5'd0) &&
                  ((use_rs && (p.dest == rs)) || (use_rt && (p.dest == rt)));
        hilo_hit = (p.hi_we && hi_rd) || (p.lo_we && lo_rd);
        return p.valid && (reg_hit || hilo_hit);
    endfunction

    assign op = instr.i_fields.op;
    assign funct = instr.r_fields.funct;
    assign imm16 = instr.i_fields.imm16;
    assign rs_addr = instr.i_fields.rs;
    assign rt_addr = instr.i_fields.rt;

    // ctrl bits run sign_ext, imm_sel, dest_sel, reg_write, hi_read, lo_read,
    // hi_write, lo_write, shift_var, use_imm, alu_op and ovf_check.
    always_comb begin
        exc = mips_pkg::EXC_NONE;
        ctrl = '0;
        if (op == mips_pkg::OP_RTYPE) begin
            case (funct)
                mips_pkg::FN_ADDU:    ctrl = 17'b0_00_01_1_0000_0_0_0000_0;
                mips_pkg::FN_ADD:     ctrl = 17'b0_00_01_1_0000_0_0_0000_1;
                mips_pkg::FN_SUBU:    ctrl = 17'b0_00_01_1_0000_0_0_0001_0;
                mips_pkg::FN_SUB:     ctrl = 17'b0_00_01_1_0000_0_0_0001_1;
                mips_pkg::FN_AND:     ctrl = 17'b0_00_01_1_0000_0_0_0010_0;
                mips_pkg::FN_OR:      ctrl = 17'b0_00_01_1_0000_0_0_0011_0;
                mips_pkg::FN_NOR:     ctrl = 17'b0_00_01_1_0000_0_0_0100_0;
                mips_pkg::FN_XOR:     ctrl = 17'b0_00_01_1_0000_0_0_0101_0;
                mips_pkg::FN_SLL:     ctrl = 17'b0_00_01_1_0000_0_0_0110_0;
                mips_pkg::FN_SRL:     ctrl = 17'b0_00_01_1_0000_0_0_0111_0;
                mips_pkg::FN_SRA:     ctrl = 17'b0_00_01_1_0000_0_0_1000_0;
                mips_pkg::FN_SLLV:    ctrl = 17'b0_00_01_1_0000_1_0_0110_0;
                mips_pkg::FN_SRLV:    ctrl = 17'b0_00_01_1_0000_1_0_0111_0;
                mips_pkg::FN_SRAV:    ctrl = 17'b0_00_01_1_0000_1_0_1000_0;
                mips_pkg::FN_SLT:     ctrl = 17'b0_00_01_1_0000_0_0_1001_0;
                mips_pkg::FN_SLTU:    ctrl = 17'b0_00_01_1_0000_0_0_1010_0;
                mips_pkg::FN_MFHI:    ctrl = 17'b0_00_01_1_1000_0_0_1110_0;
                mips_pkg::FN_MFLO:    ctrl = 17'b0_00_01_1_0100_0_0_1110_0;
                mips_pkg::FN_MTHI:    ctrl = 17'b0_00_00_0_0010_0_0_1110_0;
                mips_pkg::FN_MTLO:    ctrl = 17'b0_00_00_0_0001_0_0_1110_0;
                mips_pkg::FN_MULT:    ctrl = 17'b0_00_00_0_0011_0_0_1100_0;
                mips_pkg::FN_MULTU:   ctrl = 17'b0_00_00_0_0011_0_0_1101_0;
                mips_pkg::FN_SYSCALL: exc = mips_pkg::EXC_SYSCALL;
                mips_pkg::FN_BREAK:   exc = mips_pkg::EXC_BREAK;
                default:              exc = mips_pkg::EXC_RESERVED;
            endcase
        end else begin
            case (op)
                mips_pkg::OP_ADDIU: ctrl = 17'b1_01_10_1_0000_0_1_0000_0;
                mips_pkg::OP_ADDI:  ctrl = 17'b1_01_10_1_0000_0_1_0000_1;
                mips_pkg::OP_ANDI:  ctrl = 17'b0_01_10_1_0000_0_1_0010_0;
                mips_pkg::OP_ORI:   ctrl = 17'b0_01_10_1_0000_0_1_0011_0;
                mips_pkg::OP_XORI:  ctrl = 17'b0_01_10_1_0000_0_1_0101_0;
                mips_pkg::OP_SLTI:  ctrl = 17'b1_01_10_1_0000_0_1_1001_0;
                mips_pkg::OP_SLTIU: ctrl = 17'b1_01_10_1_0000_0_1_1010_0;
                mips_pkg::OP_LUI:   ctrl = 17'b0_10_10_1_0000_0_1_1011_0;
                // branches only report taken.
                mips_pkg::OP_BEQ, mips_pkg::OP_BNE: ctrl = '0;
                default: exc = mips_pkg::EXC_RESERVED;
            endcase
        end
    end

    assign ext_imm = ctrl.sign_ext ? {{16{imm16[15]}}, imm16} : {16'b0, imm16};

    always_comb begin
        case (ctrl.imm_sel)
            mips_pkg::IMM_EXT:   imm = ext_imm;
            mips_pkg::IMM_UPPER: imm = {imm16, 16'b0};
            mips_pkg::IMM_NONE:  imm = '0;
            default:             imm = '0;
        endcase
    end

    always_comb begin
        case (ctrl.dest_sel)
            mips_pkg::DEST_RD: dest = instr.r_fields.rd;
            mips_pkg::DEST_RT: dest = rt_addr;
            default:           dest = 5'd0;
        endcase
    end

    always_comb begin
        dx.pc = pc;
        dx.ctrl = ctrl;
        dx.dest = dest;
        dx.opa = rs_data;
        dx.opb = ctrl.use_imm ? imm : rt_data;
        dx.shamt = ctrl.shift_var ? rs_data[4:0] : instr.r_fields.shamt;
        dx.taken = ((op == mips_pkg::OP_BEQ) && (rs_data == rt_data)) ||
                   ((op == mips_pkg::OP_BNE) && (rs_data != rt_data));
        dx.exc = exc;
    end

    // lui never reads rs; only R-type words and branches read rt.
    assign rs_used = (op != mips_pkg::OP_LUI);
    assign rt_used = (op == mips_pkg::OP_RTYPE) || (op == mips_pkg::OP_BEQ) ||
                     (op == mips_pkg::OP_BNE);

    assign hazard = pending_hit(pend_x, rs_addr, rt_addr, rs_used, rt_used,
                                ctrl.hi_read, ctrl.lo_read) ||
                    pending_hit(pend_r, rs_addr, rt_addr, rs_used, rt_used,
                                ctrl.hi_read, ctrl.lo_read);
    assign stall = hazard || !dx_ready;

    // a word that reads only register 0 and neither hi nor lo never waits on a later stage.
    always_comb begin
        if (dx_ready && ((rs_addr == 5'd0) || !rs_used) && ((rt_addr == 5'd0) || !rt_used) &&
            !ctrl.hi_read && !ctrl.lo_read) begin
            assert (!stall)
            else $error("decode stalled on a register 0 hazard.");
        end
    end

endmodule

/* execute.sv */
`timescale 1ns/100ps

module execute (
    input  logic          clk,
    input  logic          reset,
    input  logic          in_valid,
    input  mips_pkg::dx_t dx,
    input  logic          out_ready,
    output logic          in_ready,
    output logic          out_valid,
    output mips_pkg::xr_t xr
);
    mips_pkg::dx_t dx_q;
    logic          valid_q;
    logic [31:0]   a;
    logic [31:0]   b;
    logic [31:0]   sum;
    logic [31:0]   diff;
    logic [63:0]   prod;
    logic [31:0]   value;
    logic          is_mult;
    logic          ovf;
    logic [2:0]    exc;

    assign in_ready = !valid_q || out_ready;
    assign out_valid = valid_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            dx_q <= dx;
        end
    end

    assign a = dx_q.opa;
    assign b = dx_q.opb;
    assign sum = a + b;
    assign diff = a - b;
    assign is_mult = (dx_q.ctrl.alu_op == mips_pkg::ALU_MULT) ||
                     (dx_q.ctrl.alu_op == mips_pkg::ALU_MULTU);

    // the low 64 bits of a product of sign-extended operands are the signed product.
    always_comb begin
        if (dx_q.ctrl.alu_op == mips_pkg::ALU_MULT) begin
            prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        end else begin
            prod = {32'b0, a} * {32'b0, b};
        end
    end

    always_comb begin
        case (dx_q.ctrl.alu_op)
            mips_pkg::ALU_ADD:  value = sum;
            mips_pkg::ALU_SUB:  value = diff;
            mips_pkg::ALU_AND:  value = a & b;
            mips_pkg::ALU_OR:   value = a | b;
            mips_pkg::ALU_NOR:  value = ~(a | b);
            mips_pkg::ALU_XOR:  value = a ^ b;
            mips_pkg::ALU_SLL:  value = b << dx_q.shamt;
            mips_pkg::ALU_SRL:  value = b >> dx_q.shamt;
            mips_pkg::ALU_SRA:  value = $signed(b) >>> dx_q.shamt;
            mips_pkg::ALU_SLT:  value = {31'b0, $signed(a) < $signed(b)};
            mips_pkg::ALU_SLTU: value = {31'b0, a < b};
            mips_pkg::ALU_LUI:  value = b;
            default:            value = a;
        endcase
    end

    assign ovf = dx_q.ctrl.ovf_check &&
                 ((dx_q.ctrl.alu_op == mips_pkg::ALU_SUB) ?
                  ((a[31] != b[31]) && (diff[31] != a[31])) :
                  ((a[31] == b[31]) && (sum[31] != a[31])));

    // a decode exception outranks overflow.
    assign exc = (dx_q.exc != mips_pkg::EXC_NONE) ? dx_q.exc :
                 (ovf ? mips_pkg::EXC_OVERFLOW : mips_pkg::EXC_NONE);

    always_comb begin
        xr.pc = dx_q.pc;
        xr.dest = dx_q.dest;
        xr.we = dx_q.ctrl.reg_write && (exc == mips_pkg::EXC_NONE);
        xr.hi_we = dx_q.ctrl.hi_write && (exc == mips_pkg::EXC_NONE);
        xr.lo_we = dx_q.ctrl.lo_write && (exc == mips_pkg::EXC_NONE);
        xr.value = value;
        xr.hi_val = is_mult ? prod[63:32] : a;
        xr.lo_val = is_mult ? prod[31:0] : a;
        xr.hi_rd = dx_q.ctrl.hi_read;
        xr.lo_rd = dx_q.ctrl.lo_read;
        xr.taken = dx_q.taken;
        xr.exc = exc;
    end

    valid_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(out_valid))
        else $error("execute out_valid is unknown.");

endmodule

/* result_stage.sv */
`timescale 1ns/100ps

module result_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  mips_pkg::xr_t      xr,
    input  logic               out_ready,
    output logic               in_ready,
    output logic               out_valid,
    output mips_pkg::retire_t  out_rec,
    output logic               wr_en,
    output logic [4:0]         wr_addr,
    output logic [31:0]        wr_data,
    output mips_pkg::pending_t pend_r
);
    mips_pkg::xr_t xr_q;
    logic          valid_q;
    logic [31:0]   hi_q;
    logic [31:0]   lo_q;
    logic          fire;

    assign in_ready = !valid_q || out_ready;
    assign out_valid = valid_q;
    assign fire = valid_q && out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            xr_q <= xr;
        end
    end

    // hi and lo are architectural, so they start cleared.
    always_ff @(posedge clk) begin
        if (reset) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (fire) begin
            if (xr_q.hi_we) begin
                hi_q <= xr_q.hi_val;
            end
            if (xr_q.lo_we) begin
                lo_q <= xr_q.lo_val;
            end
        end
    end

    always_comb begin
        out_rec.pc = xr_q.pc;
        out_rec.dest = xr_q.dest;
        out_rec.we = xr_q.we;
        if (xr_q.hi_rd) begin
            out_rec.wdata = hi_q;
        end else if (xr_q.lo_rd) begin
            out_rec.wdata = lo_q;
        end else begin
            out_rec.wdata = xr_q.value;
        end
        out_rec.taken = xr_q.taken;
        out_rec.exc = xr_q.exc;
    end

    assign wr_en = fire && xr_q.we && (xr_q.exc == mips_pkg::EXC_NONE);
    assign wr_addr = xr_q.dest;
    assign wr_data = out_rec.wdata;

    assign pend_r = '{dest: xr_q.dest, we: xr_q.we, hi_we: xr_q.hi_we,
                      lo_we: xr_q.lo_we, valid: valid_q};

    rec_held: assert property (@(posedge clk) disable iff (reset)
                               out_valid && !out_ready |=> $stable(out_rec))
        else $error("retire record changed while stalled.");

endmodule

/* core_top.sv */
`timescale 1ns/100ps

module core_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    output logic              in_ready,
    input  logic [31:0]       in_instr,
    input  logic [31:0]       in_pc,
    output logic              out_valid,
    input  logic              out_ready,
    output mips_pkg::retire_t out_rec
);
    mips_pkg::dx_t      dx;
    mips_pkg::xr_t      xr;
    mips_pkg::pending_t pend_x;
    mips_pkg::pending_t pend_r;
    logic               dx_valid;
    logic               dx_ready;
    logic               xr_valid;
    logic               xr_ready;
    logic               stall;
    logic [4:0]         rs_addr;
    logic [4:0]         rt_addr;
    logic [31:0]        rs_data;
    logic [31:0]        rt_data;
    logic               wr_en;
    logic [4:0]         wr_addr;
    logic [31:0]        wr_data;

    assign in_ready = !stall;
    assign dx_valid = in_valid && !stall;

    // writes held in the execute register.
    assign pend_x = '{dest: xr.dest, we: xr.we, hi_we: xr.hi_we,
                      lo_we: xr.lo_we, valid: xr_valid};

    decode u_decode (
        .instr    (in_instr),
        .pc       (in_pc),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .pend_x   (pend_x),
        .pend_r   (pend_r),
        .dx_ready (dx_ready),
        .rs_addr  (rs_addr),
        .rt_addr  (rt_addr),
        .dx       (dx),
        .stall    (stall)
    );

    regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    execute u_execute (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (dx_valid),
        .dx        (dx),
        .out_ready (xr_ready),
        .in_ready  (dx_ready),
        .out_valid (xr_valid),
        .xr        (xr)
    );

    result_stage u_result (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (xr_valid),
        .xr        (xr),
        .out_ready (out_ready),
        .in_ready  (xr_ready),
        .out_valid (out_valid),
        .out_rec   (out_rec),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .pend_r    (pend_r)
    );

endmodule

/* tb_model.svh */
// architectural state of the reference model.
logic [31:0] model_regs [32];
logic [31:0] model_hi;
logic [31:0] model_lo;

task automatic model_reset();
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
    end
    model_hi = '0;
    model_lo = '0;
endtask

// runs one word in program order and returns the record it should retire with.
task automatic model_retire(input logic [31:0] word, input logic [31:0] pc,
                            output mips_pkg::retire_t want);
    logic [5:0]  op;
    logic [5:0]  fn;
    logic [4:0]  sh;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] se;
    logic [31:0] ze;
    logic [31:0] res;
    logic [32:0] wide;
    logic [63:0] prod;
    logic        nodest;
    op = word[31:26];
    fn = word[5:0];
    sh = word[10:6];
    a = model_regs[word[25:21]];
    b = model_regs[word[20:16]];
    se = {{16{word[15]}}, word[15:0]};
    ze = {16'b0, word[15:0]};
    res = '0;
    nodest = 1'b0;
    want = '0;
    want.pc = pc;
    want.we = 1'b1;
    want.dest = (op == mips_pkg::OP_RTYPE) ? word[15:11] : word[20:16];
    if (op == mips_pkg::OP_RTYPE) begin
        case (fn)
            mips_pkg::FN_ADDU: res = a + b;
            mips_pkg::FN_ADD: begin
                wide = {a[31], a} + {b[31], b};
                res = wide[31:0];
                if (wide[32] != wide[31]) want.exc = mips_pkg::EXC_OVERFLOW;
            end
            mips_pkg::FN_SUBU: res = a - b;
            mips_pkg::FN_SUB: begin
                wide = {a[31], a} - {b[31], b};
                res = wide[31:0];
                if (wide[32] != wide[31]) want.exc = mips_pkg::EXC_OVERFLOW;
            end
            mips_pkg::FN_AND:  res = a & b;
            mips_pkg::FN_OR:   res = a | b;
            mips_pkg::FN_NOR:  res = ~(a | b);
            mips_pkg::FN_XOR:  res = a ^ b;
            mips_pkg::FN_SLL:  res = b << sh;
            mips_pkg::FN_SRL:  res = b >> sh;
            mips_pkg::FN_SRA:  res = $signed(b) >>> sh;
            mips_pkg::FN_SLLV: res = b << a[4:0];
            mips_pkg::FN_SRLV: res = b >> a[4:0];
            mips_pkg::FN_SRAV: res = $signed(b) >>> a[4:0];
            mips_pkg::FN_SLT:  res = {31'b0, $signed(a) < $signed(b)};
            mips_pkg::FN_SLTU: res = {31'b0, a < b};
            mips_pkg::FN_MFHI: res = model_hi;
            mips_pkg::FN_MFLO: res = model_lo;
            mips_pkg::FN_MTHI: begin
                model_hi = a;
                nodest = 1'b1;
            end
            mips_pkg::FN_MTLO: begin
                model_lo = a;
                nodest = 1'b1;
            end
            mips_pkg::FN_MULT, mips_pkg::FN_MULTU: begin
                if (fn == mips_pkg::FN_MULT) begin
                    prod = longint'($signed(a)) * longint'($signed(b));
                end else begin
                    prod = 64'(a) * 64'(b);
                end
                model_hi = prod[63:32];
                model_lo = prod[31:0];
                nodest = 1'b1;
            end
            mips_pkg::FN_SYSCALL: want.exc = mips_pkg::EXC_SYSCALL;
            mips_pkg::FN_BREAK:   want.exc = mips_pkg::EXC_BREAK;
            default:              want.exc = mips_pkg::EXC_RESERVED;
        endcase
    end else begin
        case (op)
            mips_pkg::OP_ADDIU: res = a + se;
            mips_pkg::OP_ADDI: begin
                wide = {a[31], a} + {se[31], se};
                res = wide[31:0];
                if (wide[32] != wide[31]) want.exc = mips_pkg::EXC_OVERFLOW;
            end
            mips_pkg::OP_ANDI:  res = a & ze;
            mips_pkg::OP_ORI:   res = a | ze;
            mips_pkg::OP_XORI:  res = a ^ ze;
            mips_pkg::OP_SLTI:  res = {31'b0, $signed(a) < $signed(se)};
            mips_pkg::OP_SLTIU: res = {31'b0, a < se};
            mips_pkg::OP_LUI:   res = {word[15:0], 16'b0};
            mips_pkg::OP_BEQ: begin
                want.taken = (a == b);
                nodest = 1'b1;
            end
            mips_pkg::OP_BNE: begin
                want.taken = (a != b);
                nodest = 1'b1;
            end
            default: want.exc = mips_pkg::EXC_RESERVED;
        endcase
    end
    if (nodest || (want.exc > mips_pkg::EXC_OVERFLOW)) begin
        want.we = 1'b0;
        want.dest = 5'd0;
    end
    // a faulting word leaves every register as it was.
    if (want.exc != mips_pkg::EXC_NONE) begin
        want.we = 1'b0;
    end else if (want.we && (want.dest != 5'd0)) begin
        model_regs[want.dest] = res;
    end
    want.wdata = res;
endtask

/* tb_core.sv */
`timescale 1ns/100ps

module tb_core;
    localparam int NUM_INSTR = 2000;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 8 + 100;

    logic              clk;
    logic              reset;
    logic              in_valid;
    logic              in_ready;
    logic [31:0]       in_instr;
    logic [31:0]       in_pc;
    logic              out_valid;
    logic              out_ready;
    mips_pkg::retire_t out_rec;

    logic [31:0] rng;
    logic [31:0] next_pc;
    logic        took;
    logic [31:0] word_q [$];
    logic [31:0] pc_q [$];
    int          issued;
    int          accepted;
    int          retired;
    int          cycles;
    int          extra;

    `include "tb_model.svh"

    core_top dut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_instr  (in_instr),
        .in_pc     (in_pc),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_rec   (out_rec)
    );

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // registers stay in 0..7 so that back-to-back dependencies are frequent.
    function automatic logic [31:0] make_instr(logic [31:0] r1, logic [31:0] r2);
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [5:0]  fn;
        logic [5:0]  op;
        logic [15:0] imm;
        rs = {2'b0, r1[2:0]};
        rt = {2'b0, r1[5:3]};
        rd = {2'b0, r1[8:6]};
        imm = r2[15:0];
        fn = mips_pkg::FN_ADDU;
        op = mips_pkg::OP_ADDIU;
        if (r1[31:28] < 4'd6) begin
            case (r2[19:16])
                4'd0:    fn = mips_pkg::FN_ADDU;
                4'd1:    fn = mips_pkg::FN_ADD;
                4'd2:    fn = mips_pkg::FN_SUBU;
                4'd3:    fn = mips_pkg::FN_SUB;
                4'd4:    fn = mips_pkg::FN_AND;
                4'd5:    fn = mips_pkg::FN_OR;
                4'd6:    fn = mips_pkg::FN_NOR;
                4'd7:    fn = mips_pkg::FN_XOR;
                4'd8:    fn = mips_pkg::FN_SLL;
                4'd9:    fn = mips_pkg::FN_SRL;
                4'd10:   fn = mips_pkg::FN_SRA;
                4'd11:   fn = mips_pkg::FN_SLLV;
                4'd12:   fn = mips_pkg::FN_SRLV;
                4'd13:   fn = mips_pkg::FN_SRAV;
                4'd14:   fn = mips_pkg::FN_SLT;
                default: fn = mips_pkg::FN_SLTU;
            endcase
            return {mips_pkg::OP_RTYPE, rs, rt, rd, r1[13:9], fn};
        end else if (r1[31:28] < 4'd8) begin
            case (r2[18:16])
                3'd0:    fn = mips_pkg::FN_MFHI;
                3'd1:    fn = mips_pkg::FN_MFLO;
                3'd2:    fn = mips_pkg::FN_MTHI;
                3'd3:    fn = mips_pkg::FN_MTLO;
                3'd4:    fn = mips_pkg::FN_MULT;
                3'd5:    fn = mips_pkg::FN_MULTU;
                3'd6:    fn = mips_pkg::FN_MULT;
                default: fn = mips_pkg::FN_MFHI;
            endcase
            return {mips_pkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};
        end else if (r1[31:28] < 4'd13) begin
            case (r2[18:16])
                3'd0:    op = mips_pkg::OP_ADDIU;
                3'd1:    op = mips_pkg::OP_ADDI;
                3'd2:    op = mips_pkg::OP_ANDI;
                3'd3:    op = mips_pkg::OP_ORI;
                3'd4:    op = mips_pkg::OP_XORI;
                3'd5:    op = mips_pkg::OP_SLTI;
                3'd6:    op = mips_pkg::OP_SLTIU;
                default: op = mips_pkg::OP_LUI;
            endcase
            // upper halves near the sign boundary make overflow common.
            if ((op == mips_pkg::OP_LUI) && !r2[20]) begin
                imm = r2[21] ? 16'h7fff : 16'h8000;
            end
            return {op, rs, rt, imm};
        end else if (r1[31:28] < 4'd15) begin
            return {r2[16] ? mips_pkg::OP_BNE : mips_pkg::OP_BEQ, rs, rt, imm};
        end else if (r1[27]) begin
            case (r2[27:26])
                2'd0:    return {6'h02, r2[25:0]};
                2'd1:    return {6'h23, r2[25:0]};
                2'd2:    return {6'h3f, r2[25:0]};
                default: return {mips_pkg::OP_RTYPE, r2[25:6], 6'h1a};
            endcase
        end else begin
            return {mips_pkg::OP_RTYPE, r2[25:6],
                    r2[16] ? mips_pkg::FN_BREAK : mips_pkg::FN_SYSCALL};
        end
    endfunction

    task automatic report_failure(string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(string what, logic [31:0] got, logic [31:0] want);
        if (got !== want) begin
            report_failure($sformatf("Error at %0t: %s is %h, expected %h",
                                     $time, what, got, want));
        end
    endtask

    task automatic check_retire();
        mips_pkg::retire_t want;
        logic [31:0]       word;
        logic [31:0]       pc;
        if (word_q.size() == 0) begin
            report_failure("a record retired with no accepted instruction left");
        end else begin
            word = word_q.pop_front();
            pc = pc_q.pop_front();
            model_retire(word, pc, want);
            check_value("pc", out_rec.pc, want.pc);
            check_value("exc", {29'b0, out_rec.exc}, {29'b0, want.exc});
            check_value("we", {31'b0, out_rec.we}, {31'b0, want.we});
            check_value("taken", {31'b0, out_rec.taken}, {31'b0, want.taken});
            check_value("dest", {27'b0, out_rec.dest}, {27'b0, want.dest});
            if (want.we) begin
                check_value("wdata", out_rec.wdata, want.wdata);
            end
            retired++;
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] r1;
        logic [31:0] r2;
        if (took) begin
            in_valid = 1'b0;
        end
        rng = xorshift(rng);
        out_ready = (rng[1:0] != 2'b00);
        if (!in_valid && (issued < NUM_INSTR)) begin
            rng = xorshift(rng);
            r1 = rng;
            rng = xorshift(rng);
            r2 = rng;
            if (r2[31:30] != 2'b00) begin
                in_instr = make_instr(r1, r2);
                in_pc = next_pc;
                next_pc = next_pc + 32'd4;
                issued++;
                in_valid = 1'b1;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        in_valid = 1'b0;
        in_instr = '0;
        in_pc = '0;
        out_ready = 1'b0;
        rng = 32'd68;
        next_pc = 32'h0040_0000;
        took = 1'b0;
        issued = 0;
        accepted = 0;
        retired = 0;
        cycles = 0;
        extra = 0;
        model_reset();
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while ((retired < NUM_INSTR) && (cycles < TIMEOUT_CYCLES)) begin
            @(negedge clk);
            drive_inputs();
            // handshakes are settled halfway between the falling and the rising edge.
            #1;
            took = in_valid && in_ready;
            if (took) begin
                word_q.push_back(in_instr);
                pc_q.push_back(in_pc);
                accepted++;
            end
            if (out_valid && out_ready) begin
                check_retire();
            end
            cycles++;
        end
        // an idle pipeline must not emit any further record.
        repeat (20) begin
            @(negedge clk);
            in_valid = 1'b0;
            out_ready = 1'b1;
            #1;
            if (out_valid) begin
                extra++;
            end
        end
        if (retired < NUM_INSTR) begin
            report_failure("timeout: retirement stalled before all instructions retired");
        end else if ((extra == 0) && (accepted == retired) && (word_q.size() == 0)) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            report_failure("retired record count does not match accepted instruction count");
        end
    end

endmodule

/* list.f */
+incdir+.
mips_pkg.sv
regfile.sv
decode.sv
execute.sv
result_stage.sv
core_top.sv
tb_core.sv

/* run.sh */
#!/usr/bin/env bash
rm -f sim.log
verilator --binary --timing -f list.f --top-module tb_core -o sim_tb_core > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_tb_core > sim.log 2>&1 || true
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
